/* Makefile */
# Verilator flow for the instruction fetch unit

VERILATOR ?= verilator
TOP       ?= tb_ifu
RTL_TOP   ?= ifu_top
FILELIST  ?= ifu_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= test failed
PASS_MSG  ?= test passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: build
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without a result"; exit 1; fi
	@echo "simulation clean"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* ifu_top.f */
verilog/axi_lite_pkg.sv
verilog/fetch_pkg.sv
verilog/fetch_ctrl.sv
verilog/bus_timer.sv
verilog/pc_gen.sv
verilog/inst_align.sv
verilog/ifu_top.sv
tests/axi_mem_model.sv
tests/tb_ifu.sv

/* tests/axi_mem_model.sv */
`timescale 1ns/1ps

module axi_mem_model #(
    parameter logic [31:0] PATTERN_KEY = 32'h0,
    parameter logic [63:0] ERR_BASE    = 64'h0,
    parameter logic [63:0] SILENT_BASE = 64'h0
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  axi_lite_pkg::axi_ar_req_t ar_req,
    output logic                      arready,
    output axi_lite_pkg::axi_r_rsp_t  r_rsp,
    input  logic                      rready
);
    import axi_lite_pkg::*;

    logic        busy;    // address taken, data still owed
    logic [63:0] addr;
    int unsigned delay;   // cycles left before the next answer

    // every 32-bit word carries its own address, folded to 32 bits
    function automatic logic [31:0] word_at(input logic [63:0] a);
        return a[63:32] ^ a[31:0] ^ PATTERN_KEY;
    endfunction

    function automatic logic in_region(input logic [63:0] a, input logic [63:0] base);
        return a[63:8] == base[63:8];   // 256-byte regions
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arready <= 1'b0;
            r_rsp   <= '0;
            busy    <= 1'b0;
            addr    <= '0;
            delay   <= 0;
        end else if (!busy) begin
            if (ar_req.arvalid && arready) begin
                arready <= 1'b0;
                busy    <= 1'b1;
                addr    <= ar_req.araddr;
                delay   <= $urandom_range(5, 0);
            end else if (!ar_req.arvalid) begin
                arready <= 1'b0;   // master may give up after its timeout
                delay   <= $urandom_range(5, 0);
            end else if (in_region(ar_req.araddr, SILENT_BASE)) begin
                arready <= 1'b0;   // never answers here
            end else if (delay == 0) begin
                arready <= 1'b1;
            end else begin
                delay <= delay - 1;
            end
        end else if (r_rsp.rvalid) begin
            if (rready) begin
                r_rsp <= '0;
                busy  <= 1'b0;
            end
        end else if (delay == 0) begin
            r_rsp.rvalid <= 1'b1;
            r_rsp.rlast  <= 1'b1;
            r_rsp.rdata  <= {word_at({addr[63:3], 3'b100}), word_at({addr[63:3], 3'b000})};
            r_rsp.rresp  <= in_region(addr, ERR_BASE) ? RESP_SLVERR : RESP_OKAY;
        end else begin
            delay <= delay - 1;
        end
    end

endmodule

/* tests/tb_ifu.sv */
`timescale 1ns/1ps

module tb_ifu;
    import axi_lite_pkg::*;
    import fetch_pkg::*;

    localparam logic [31:0] PATTERN_KEY = 32'h5a3c_96e1;
    localparam pc_t         ERR_BASE    = 64'h0000_0000_8000_1000;   // answers SLVERR
    localparam pc_t         SILENT_BASE = 64'h0000_0000_8000_2000;   // never answers
    localparam int unsigned LAT_LIMIT   = int'(BUS_TIMEOUT) + 4;

    logic        clk;
    logic        rst_n;
    logic        fetch_en;
    axi_ar_req_t ar_req;
    logic        arready;
    axi_r_rsp_t  r_rsp;
    logic        rready;
    fetch_pkt_t  inst_pkt;
    logic        inst_valid;
    logic        inst_ready;
    logic        redirect_valid;
    pc_t         redirect_pc;

    pc_t         exp_pc;       // reference pc of the current fetch
    logic        exp_err;
    inst_t       exp_inst;
    logic        accept;
    logic        ar_silent;
    fetch_pkt_t  last_pkt;
    int unsigned bus_cycles;   // cycles in ADDR and DATA so far

    ifu_top u_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .fetch_en       (fetch_en),
        .ar_req         (ar_req),
        .arready        (arready),
        .r_rsp          (r_rsp),
        .rready         (rready),
        .inst_pkt       (inst_pkt),
        .inst_valid     (inst_valid),
        .inst_ready     (inst_ready),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    axi_mem_model #(
        .PATTERN_KEY (PATTERN_KEY),
        .ERR_BASE    (ERR_BASE),
        .SILENT_BASE (SILENT_BASE)
    ) u_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .ar_req  (ar_req),
        .arready (arready),
        .r_rsp   (r_rsp),
        .rready  (rready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    assign accept    = inst_valid && inst_ready;
    assign ar_silent = (ar_req.araddr[63:8] == SILENT_BASE[63:8]);
    assign exp_err   = (exp_pc[63:8] == ERR_BASE[63:8]) || (exp_pc[63:8] == SILENT_BASE[63:8]);
    assign exp_inst  = exp_err ? '0 : (exp_pc[63:32] ^ exp_pc[31:0] ^ PATTERN_KEY);

    // reference pc follows the core side handshake
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_pc     <= RESET_PC;
            last_pkt   <= '0;
            bus_cycles <= 0;
        end else begin
            if (accept) begin
                exp_pc <= redirect_valid ? (redirect_pc & ~64'h3) : exp_pc + 64'd4;
            end
            last_pkt   <= inst_pkt;
            bus_cycles <= (ar_req.arvalid || rready) ? bus_cycles + 1 : 0;
        end
    end

    task automatic end_in_failure();
        $display("test failed");
        $fatal(1);
    endtask

    task automatic abort(input string what);
        $display("%s", what);
        end_in_failure();
    endtask

    task automatic report_mismatch(input string name, input string expected, input string actual);
        $display("Fail %s: expected %s, actual %s", name, expected, actual);
        end_in_failure();
    endtask

    reset_idle: assert property (@(posedge clk) !rst_n |=> !ar_req.arvalid && !rready && !inst_valid)
        else report_mismatch("reset_idle", "000", $sformatf("%b%b%b",
            $sampled(ar_req.arvalid), $sampled(rready), $sampled(inst_valid)));
    fetch_addr: assert property (@(posedge clk) disable iff (!rst_n)
        ar_req.arvalid |-> ar_req.araddr == exp_pc)
        else report_mismatch("fetch_addr", $sformatf("%h", $sampled(exp_pc)),
            $sformatf("%h", $sampled(ar_req.araddr)));
    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ar_req.arvalid && !arready && !ar_silent |=> ar_req.arvalid)
        else report_mismatch("ar_hold", "1", $sformatf("%b", $sampled(ar_req.arvalid)));
    idle_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !fetch_en && !ar_req.arvalid && !rready && !inst_valid |=> !ar_req.arvalid)
        else report_mismatch("idle_hold", "0", $sformatf("%b", $sampled(ar_req.arvalid)));
    bus_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        inst_valid |-> !ar_req.arvalid && !rready)
        else report_mismatch("bus_quiet", "00",
            $sformatf("%b%b", $sampled(ar_req.arvalid), $sampled(rready)));
    pkt_hold: assert property (@(posedge clk) disable iff (!rst_n)
        inst_valid && !inst_ready |=> inst_valid && inst_pkt == last_pkt)
        else report_mismatch("pkt_hold", $sformatf("%h", $sampled(last_pkt)),
            $sformatf("%h", $sampled(inst_pkt)));
    pkt_pc: assert property (@(posedge clk) disable iff (!rst_n) accept |-> inst_pkt.pc == exp_pc)
        else report_mismatch("pkt_pc", $sformatf("%h", $sampled(exp_pc)),
            $sformatf("%h", $sampled(inst_pkt.pc)));
    pkt_inst: assert property (@(posedge clk) disable iff (!rst_n)
        accept |-> inst_pkt.inst == exp_inst)
        else report_mismatch("pkt_inst", $sformatf("%h", $sampled(exp_inst)),
            $sformatf("%h", $sampled(inst_pkt.inst)));
    pkt_err: assert property (@(posedge clk) disable iff (!rst_n) accept |-> inst_pkt.err == exp_err)
        else report_mismatch("pkt_err", $sformatf("%b", $sampled(exp_err)),
            $sformatf("%b", $sampled(inst_pkt.err)));
    fetch_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(inst_valid) |-> bus_cycles <= LAT_LIMIT)
        else report_mismatch("fetch_latency", $sformatf("<= %0d", LAT_LIMIT),
            $sformatf("%0d", $sampled(bus_cycles)));

    task automatic wait_for_packet(input int unsigned limit);
        int unsigned n;
        n = 0;
        @(posedge clk);
        while (!inst_valid) begin
            if (n >= limit) begin
                abort("no instruction packet arrived within the cycle limit");
            end
            n++;
            @(posedge clk);
        end
    endtask

    // stall the core for a while, then accept with an optional redirect
    task automatic take_packet(input logic redir, input pc_t target, input int unsigned stall);
        wait_for_packet(LAT_LIMIT + 16);
        repeat (stall) @(posedge clk);
        inst_ready     <= 1'b1;
        redirect_valid <= redir;
        redirect_pc    <= target;
        @(posedge clk);
        inst_ready     <= 1'b0;
        redirect_valid <= 1'b0;
    endtask

    initial begin
        void'($urandom(72719));
        rst_n          = 1'b0;
        fetch_en       = 1'b0;
        inst_ready     = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        repeat (2) @(posedge clk);
        rst_n    <= 1'b1;
        fetch_en <= 1'b1;

        repeat (8) take_packet(1'b0, '0, $urandom_range(3, 0));   // both lanes
        take_packet(1'b1, 64'h0000_0000_8000_0106, 0);            // unaligned target
        repeat (3) take_packet(1'b0, '0, $urandom_range(3, 0));
        take_packet(1'b1, ERR_BASE + 64'h8, 1);
        take_packet(1'b0, '0, 0);                                 // slave error, then plus 4
        take_packet(1'b1, SILENT_BASE + 64'h4, 2);
        take_packet(1'b1, 64'h0000_0000_8000_0400, 1);            // timed out packet
        repeat (3) take_packet(1'b0, '0, $urandom_range(3, 0));
        fetch_en <= 1'b0;
        take_packet(1'b0, '0, 0);                                 // back to IDLE
        repeat (8) @(posedge clk);

        $display("test passed");
        $finish;
    end

endmodule

/* verilog/axi_lite_pkg.sv */
package axi_lite_pkg;

    // read response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // read address channel, master to slave
    typedef struct packed {
        logic [63:0] araddr;
        logic        arvalid;
    } axi_ar_req_t;

    // read data channel, slave to master
    typedef struct packed {
        logic [63:0] rdata;
        logic [1:0]  rresp;   // OKAY or SLVERR
        logic        rlast;   // single beat, always set by the slave
        logic        rvalid;
    } axi_r_rsp_t;

endpackage

/* verilog/bus_timer.sv */
`timescale 1ns/1ps

module bus_timer (
    input  logic clk,
    input  logic rst_n,
    input  logic run,
    output logic expired
);
    import fetch_pkg::*;

    logic [TIMER_W-1:0] count;

    // saturates at the limit, cleared whenever the bus is idle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (!run) begin
            count <= '0;
        end else if (count != BUS_TIMEOUT) begin
            count <= count + 1'b1;
        end
    end

    assign expired = (count == BUS_TIMEOUT);   // held until run drops

endmodule

/* verilog/fetch_ctrl.sv */
`timescale 1ns/1ps

module fetch_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic fetch_en,
    input  logic arready,
    input  logic rvalid,
    input  logic rlast,
    input  logic timer_expired,
    input  logic inst_ready,
    output logic arvalid,
    output logic rready,
    output logic inst_valid,
    output logic timer_run,
    output logic capture,
    output logic pc_advance
);
    import fetch_pkg::*;

    fetch_state_t state;
    fetch_state_t state_nxt;
    logic         beat_done;   // last read beat seen
    logic         accepted;    // core took the packet

    assign beat_done = rvalid && rlast;
    assign accepted  = inst_valid && inst_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // one transaction at a time, address then data then delivery
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (fetch_en) begin
                    state_nxt = ADDR;
                end
            end
            ADDR: begin
                // timeout wins over a late arready
                if (timer_expired) begin
                    state_nxt = DELIVER;
                end else if (arready) begin
                    state_nxt = DATA;
                end
            end
            DATA: begin
                if (beat_done || timer_expired) begin
                    state_nxt = DELIVER;
                end
            end
            DELIVER: begin
                if (accepted) begin
                    state_nxt = fetch_en ? ADDR : IDLE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    // handshakes come straight from the state
    assign arvalid    = (state == ADDR);
    assign rready     = (state == DATA);
    assign inst_valid = (state == DELIVER);

    // watchdog runs over the whole bus transaction
    assign timer_run = (state == ADDR) || (state == DATA);

    // load the aligner on the good beat or on the error path
    assign capture = ((state == DATA) && beat_done)
                   || (timer_run && timer_expired);

    assign pc_advance = accepted;   // pc moves once per delivered packet

endmodule

/* verilog/fetch_pkg.sv */
package fetch_pkg;

    typedef logic [63:0] pc_t;
    typedef logic [31:0] inst_t;

    // one fetched word as the core sees it
    typedef struct packed {
        pc_t   pc;
        inst_t inst;   // zero when err is set
        logic  err;    // slave error or bus timeout
    } fetch_pkt_t;

    typedef enum logic [1:0] {
        IDLE,
        ADDR,      // arvalid up, waiting for arready
        DATA,      // rready up, waiting for the last beat
        DELIVER    // packet held until the core takes it
    } fetch_state_t;

    localparam pc_t RESET_PC = 64'h0000_0000_8000_0000;

    // bus watchdog
    localparam int unsigned TIMER_W = 7;
    localparam logic [TIMER_W-1:0] BUS_TIMEOUT = 7'd64;

endpackage

/* verilog/ifu_top.sv */
`timescale 1ns/1ps

module ifu_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      fetch_en,
    output axi_lite_pkg::axi_ar_req_t ar_req,
    input  logic                      arready,
    input  axi_lite_pkg::axi_r_rsp_t  r_rsp,
    output logic                      rready,
    output fetch_pkg::fetch_pkt_t     inst_pkt,
    output logic                      inst_valid,
    input  logic                      inst_ready,
    input  logic                      redirect_valid,
    input  fetch_pkg::pc_t            redirect_pc
);
    import fetch_pkg::*;

    logic arvalid;
    logic timer_run;
    logic timer_expired;
    logic capture;
    logic pc_advance;
    pc_t  fetch_pc;   // current fetch address, stable until acceptance

    assign ar_req.araddr  = fetch_pc;
    assign ar_req.arvalid = arvalid;

    fetch_ctrl u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .fetch_en      (fetch_en),
        .arready       (arready),
        .rvalid        (r_rsp.rvalid),
        .rlast         (r_rsp.rlast),
        .timer_expired (timer_expired),
        .inst_ready    (inst_ready),
        .arvalid       (arvalid),
        .rready        (rready),
        .inst_valid    (inst_valid),
        .timer_run     (timer_run),
        .capture       (capture),
        .pc_advance    (pc_advance)
    );

    bus_timer u_timer (
        .clk     (clk),
        .rst_n   (rst_n),
        .run     (timer_run),
        .expired (timer_expired)
    );

    pc_gen u_pc (
        .clk            (clk),
        .rst_n          (rst_n),
        .advance        (pc_advance),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .pc             (fetch_pc)
    );

    inst_align u_align (
        .clk     (clk),
        .rst_n   (rst_n),
        .capture (capture),
        .timeout (timer_expired),
        .pc      (fetch_pc),
        .r_rsp   (r_rsp),
        .pkt     (inst_pkt)
    );

endmodule

/* verilog/inst_align.sv */
`timescale 1ns/1ps

module inst_align (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      capture,
    input  logic                      timeout,
    input  fetch_pkg::pc_t            pc,
    input  axi_lite_pkg::axi_r_rsp_t  r_rsp,
    output fetch_pkg::fetch_pkt_t     pkt
);
    import axi_lite_pkg::*;
    import fetch_pkg::*;

    logic  err;
    inst_t word;

    // rresp means nothing on a timeout, so err covers both cases
    assign err = timeout || (r_rsp.rresp != RESP_OKAY);

    // pc bit 2 picks the 32-bit lane of the 64-bit beat
    assign word = pc[2] ? r_rsp.rdata[63:32] : r_rsp.rdata[31:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pkt <= '0;
        end else if (capture) begin
            pkt.pc   <= pc;
            pkt.inst <= err ? '0 : word;
            pkt.err  <= err;
        end
    end

endmodule

/* verilog/pc_gen.sv */
`timescale 1ns/1ps

module pc_gen (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            advance,
    input  logic            redirect_valid,
    input  fetch_pkg::pc_t  redirect_pc,
    output fetch_pkg::pc_t  pc
);
    import fetch_pkg::*;

    pc_t target;   // redirect forced to a word boundary
    pc_t pc_nxt;

    assign target = {redirect_pc[63:2], 2'b00};

    // redirect only counts on the accepting cycle
    assign pc_nxt = redirect_valid ? target : pc + 64'd4;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else if (advance) begin
            pc <= pc_nxt;
        end
    end

endmodule
